//--- build.f
src/noc_cfg_pkg.sv
src/alloc_types_pkg.sv
src/rr_arbiter.sv
src/sw_input_stage.sv
src/sw_output_stage.sv
src/vc_alloc_stage.sv
src/comb_nonspec_allocator.sv
testbench/allocator_props.sv
testbench/allocator_tb.sv

//--- src/alloc_types_pkg.sv
`default_nettype none

package alloc_types_pkg;

    import noc_cfg_pkg::*;

    typedef logic [NUM_VCS-1:0]   vc_mask_t;    // vc set of one port
    typedef logic [NUM_DST-1:0]   dst_mask_t;   // relative destination set
    typedef logic [NUM_PORTS-1:0] port_mask_t;  // one bit per absolute port

    // state of one input vc as seen by the allocator
    typedef struct packed {
        logic      req;
        logic      ovc_assigned;
        logic      ovc_not_full;
        logic      single_flit;
        logic      weight_consumed;  // wrr quota used up
        dst_mask_t dest;
        vc_mask_t  ovc_req;          // free ovcs it may take, already masked
    } ivc_info_t;

    // first-level winner of one input port
    typedef struct packed {
        vc_mask_t  winner;
        dst_mask_t win_dest;
        logic      win_single_flit;
        logic      win_ovc_assigned;
        logic      win_weight_consumed;
    } iport_win_t;

    // grants handed back to one input port
    typedef struct packed {
        vc_mask_t  sw_grant;
        dst_mask_t dst_grant;
        vc_mask_t  ovc_num;
        vc_mask_t  ivc_gets_ovc;
    } iport_grant_t;

endpackage

`default_nettype wire

//--- src/comb_nonspec_allocator.sv
`timescale 1ns/1ps
`default_nettype none

// combined vc allocator and non-speculative switch allocator
module comb_nonspec_allocator
    import noc_cfg_pkg::*, alloc_types_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  ivc_info_t    ivc_info [NUM_PORTS][NUM_VCS],
    input  port_mask_t   iport_weight_consumed,
    output iport_grant_t iport_grant [NUM_PORTS],
    output port_mask_t   any_sw_grant,     // per input port
    output port_mask_t   any_out_grant,    // per output port
    output vc_mask_t     ovc_allocated [NUM_PORTS],
    output port_mask_t   single_flit_dst
);

    iport_win_t win       [NUM_PORTS];
    dst_mask_t  dst_grant [NUM_PORTS];

    // first level, one vc per input port
    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_in
        sw_input_stage u_in (
            .clk      (clk),
            .rst      (rst),
            .ivc_info (ivc_info[p]),
            .port_won (any_sw_grant[p]),
            .win      (win[p])
        );
    end

    // second level, one input per output port
    sw_output_stage u_out (
        .clk                   (clk),
        .rst                   (rst),
        .win                   (win),
        .iport_weight_consumed (iport_weight_consumed),
        .dst_grant             (dst_grant),
        .any_sw_grant          (any_sw_grant),
        .any_out_grant         (any_out_grant),
        .single_flit_dst       (single_flit_dst)
    );

    vc_alloc_stage u_vc (
        .clk           (clk),
        .rst           (rst),
        .ivc_info      (ivc_info),
        .win           (win),
        .dst_grant     (dst_grant),
        .any_sw_grant  (any_sw_grant),
        .grant         (iport_grant),
        .ovc_allocated (ovc_allocated)
    );

endmodule

`default_nettype wire

//--- src/noc_cfg_pkg.sv
`default_nettype none

package noc_cfg_pkg;

    localparam int NUM_PORTS = 5;              // router ports
    localparam int NUM_VCS   = 2;              // virtual channels per port
    localparam int NUM_DST   = NUM_PORTS - 1;  // no self loop

    // relative destination index k seen from input iport, to absolute output
    function automatic int rel_to_abs(input int iport, input int k);
        if (k < iport) begin
            return k;
        end
        return k + 1;
    endfunction

    // absolute port o, to relative index seen from port iport
    function automatic int abs_to_rel(input int iport, input int o);
        if (o < iport) begin
            return o;
        end
        return o - 1;
    endfunction

endpackage

`default_nettype wire

//--- src/rr_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

// round-robin arbiter, pointer only moves when update_en is set
module rr_arbiter #(
    parameter int WIDTH = 4
) (
    input  logic             clk,
    input  logic             rst,
    input  logic [WIDTH-1:0] request,
    input  logic             update_en,
    output logic [WIDTH-1:0] grant,
    output logic             any_grant
);

    logic [WIDTH-1:0]   prio;     // one-hot, position with highest priority
    logic [2*WIDTH-1:0] req_dbl;  // request repeated for wrap-around
    logic [2*WIDTH-1:0] gnt_dbl;

    assign req_dbl = {request, request};

    // lowest set request at or above the priority position
    assign gnt_dbl = req_dbl & ~(req_dbl - {{WIDTH{1'b0}}, prio});

    assign grant     = gnt_dbl[WIDTH-1:0] | gnt_dbl[2*WIDTH-1:WIDTH];
    assign any_grant = |request;

    always_ff @(posedge clk) begin
        if (rst) begin
            prio <= WIDTH'(1);  // index 0 first
        end else if (update_en && any_grant) begin
            // next index after the winner gets top priority
            prio <= {grant[WIDTH-2:0], grant[WIDTH-1]};
        end
    end

endmodule

`default_nettype wire

//--- src/sw_input_stage.sv
`timescale 1ns/1ps
`default_nettype none

// first-level switch arbitration inside one input port
module sw_input_stage
    import noc_cfg_pkg::*, alloc_types_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  ivc_info_t  ivc_info [NUM_VCS],
    input  logic       port_won,  // any_sw_grant of this port
    output iport_win_t win
);

    vc_mask_t masked_req;
    vc_mask_t first_grant;
    logic     upd;

    // a vc may compete when its own ovc has room, or when it still needs one
    always_comb begin
        for (int v = 0; v < NUM_VCS; v++) begin
            masked_req[v] = (ivc_info[v].req
                             & ivc_info[v].ovc_assigned
                             & ivc_info[v].ovc_not_full)
                            | (|ivc_info[v].ovc_req);
        end
    end

    assign upd = port_won & win.win_weight_consumed;  // wrr with external enable

    rr_arbiter #(
        .WIDTH(NUM_VCS)
    ) u_vc_arb (
        .clk       (clk),
        .rst       (rst),
        .request   (masked_req),
        .update_en (upd),
        .grant     (first_grant),
        .any_grant ()
    );

    // one-hot mux of the winning vc's fields
    always_comb begin
        win        = '0;
        win.winner = first_grant;
        for (int v = 0; v < NUM_VCS; v++) begin
            if (first_grant[v]) begin
                win.win_dest            |= ivc_info[v].dest;
                win.win_single_flit     |= ivc_info[v].single_flit;
                win.win_ovc_assigned    |= ivc_info[v].ovc_assigned;
                win.win_weight_consumed |= ivc_info[v].weight_consumed;
            end
        end
    end

endmodule

`default_nettype wire

//--- src/sw_output_stage.sv
`timescale 1ns/1ps
`default_nettype none

// second-level switch arbitration, one arbiter per output port
module sw_output_stage
    import noc_cfg_pkg::*, alloc_types_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  iport_win_t win [NUM_PORTS],
    input  port_mask_t iport_weight_consumed,
    output dst_mask_t  dst_grant [NUM_PORTS],  // relative, per input port
    output port_mask_t any_sw_grant,           // per input port
    output port_mask_t any_out_grant,          // per output port
    output port_mask_t single_flit_dst
);

    // all of these are indexed [output][relative input]
    dst_mask_t  out_req   [NUM_PORTS];
    dst_mask_t  out_grant [NUM_PORTS];
    dst_mask_t  out_wc    [NUM_PORTS];
    dst_mask_t  out_sf    [NUM_PORTS];
    port_mask_t out_upd;

    // crossbar from input-relative destinations to output-relative requests
    always_comb begin : req_map
        int p;
        for (int o = 0; o < NUM_PORTS; o++) begin
            for (int j = 0; j < NUM_DST; j++) begin
                p             = rel_to_abs(o, j);
                out_req[o][j] = win[p].win_dest[abs_to_rel(p, o)];
                out_wc[o][j]  = iport_weight_consumed[p];
                out_sf[o][j]  = win[p].win_single_flit;
            end
        end
    end

    for (genvar o = 0; o < NUM_PORTS; o++) begin : g_out
        // pointer moves only once the granted port used its weight
        assign out_upd[o] = |(out_grant[o] & out_wc[o]);

        rr_arbiter #(
            .WIDTH(NUM_DST)
        ) u_out_arb (
            .clk       (clk),
            .rst       (rst),
            .request   (out_req[o]),
            .update_en (out_upd[o]),
            .grant     (out_grant[o]),
            .any_grant (any_out_grant[o])
        );

        assign single_flit_dst[o] = |(out_grant[o] & out_sf[o]);
    end

    // grants back into each input's relative numbering
    always_comb begin : grant_map
        int o;
        for (int p = 0; p < NUM_PORTS; p++) begin
            for (int k = 0; k < NUM_DST; k++) begin
                o               = rel_to_abs(p, k);
                dst_grant[p][k] = out_grant[o][abs_to_rel(o, p)];
            end
            any_sw_grant[p] = |dst_grant[p];
        end
    end

endmodule

`default_nettype wire

//--- src/vc_alloc_stage.sv
`timescale 1ns/1ps
`default_nettype none

// output vc allocation riding on the switch allocation result
module vc_alloc_stage
    import noc_cfg_pkg::*, alloc_types_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  ivc_info_t    ivc_info [NUM_PORTS][NUM_VCS],
    input  iport_win_t   win [NUM_PORTS],
    input  dst_mask_t    dst_grant [NUM_PORTS],
    input  port_mask_t   any_sw_grant,
    output iport_grant_t grant [NUM_PORTS],
    output vc_mask_t     ovc_allocated [NUM_PORTS]  // per output port
);

    vc_mask_t cand     [NUM_PORTS][NUM_VCS];  // candidate ovc of each input vc
    vc_mask_t win_cand [NUM_PORTS];           // candidate of the port's winner
    vc_mask_t gets_ovc [NUM_PORTS];

    // each input vc keeps its own candidate pointer
    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
        for (genvar v = 0; v < NUM_VCS; v++) begin : g_vc
            rr_arbiter #(
                .WIDTH(NUM_VCS)
            ) u_ovc_arb (
                .clk       (clk),
                .rst       (rst),
                .request   (ivc_info[p][v].ovc_req),
                .update_en (gets_ovc[p][v]),  // only after it got an ovc
                .grant     (cand[p][v]),
                .any_grant ()
            );
        end
    end

    always_comb begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            win_cand[p] = '0;
            for (int v = 0; v < NUM_VCS; v++) begin
                if (win[p].winner[v]) begin
                    win_cand[p] |= cand[p][v];
                end
            end

            // a new ovc only goes to a winner that has none yet
            gets_ovc[p] = '0;
            if (any_sw_grant[p] && !win[p].win_ovc_assigned) begin
                gets_ovc[p] = win[p].winner;
            end

            grant[p].sw_grant     = any_sw_grant[p] ? win[p].winner : '0;
            grant[p].dst_grant    = dst_grant[p];
            grant[p].ovc_num      = any_sw_grant[p] ? win_cand[p] : '0;
            grant[p].ivc_gets_ovc = gets_ovc[p];
        end
    end

    // ovcs taken at each output, from the input granted there
    always_comb begin
        for (int o = 0; o < NUM_PORTS; o++) begin
            ovc_allocated[o] = '0;
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (p != o && dst_grant[p][abs_to_rel(p, o)]) begin
                    ovc_allocated[o] |= win_cand[p];
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- testbench/allocator_props.sv
`timescale 1ns/1ps
`default_nettype none

// grant consistency checks on the allocator outputs
module allocator_props
    import noc_cfg_pkg::*, alloc_types_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  iport_grant_t iport_grant [NUM_PORTS],
    input  port_mask_t   any_out_grant,
    input  vc_mask_t     ovc_allocated [NUM_PORTS]
);

    port_mask_t out_or;  // per output, OR of the matching dst_grant bits

    // bit k of a dst_grant is output k below the input's own index, else k+1
    always_comb begin
        for (int o = 0; o < NUM_PORTS; o++) begin
            out_or[o] = 1'b0;
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (p < o) begin
                    out_or[o] |= iport_grant[p].dst_grant[o - 1];
                end else if (p > o) begin
                    out_or[o] |= iport_grant[p].dst_grant[o];
                end
            end
        end
    end

    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
        a_sw_onehot: assert property (@(posedge clk) disable iff (rst)
            $onehot0(iport_grant[p].sw_grant))
            else $error("sw_grant of input %0d has more than one bit set", p);

        // a new ovc only goes along with a switch grant
        a_ovc_needs_sw: assert property (@(posedge clk) disable iff (rst)
            (iport_grant[p].ivc_gets_ovc & ~iport_grant[p].sw_grant) == '0)
            else $error("input %0d gets an ovc without a switch grant", p);
    end

    for (genvar o = 0; o < NUM_PORTS; o++) begin : g_out
        a_out_or: assert property (@(posedge clk) disable iff (rst)
            any_out_grant[o] == out_or[o])
            else $error("any_out_grant of output %0d disagrees with dst_grant", o);

        a_ovc_idle: assert property (@(posedge clk) disable iff (rst)
            !any_out_grant[o] |-> ovc_allocated[o] == '0)
            else $error("output %0d shows an ovc taken without a grant", o);
    end

endmodule

bind comb_nonspec_allocator allocator_props u_props (
    .clk           (clk),
    .rst           (rst),
    .iport_grant   (iport_grant),
    .any_out_grant (any_out_grant),
    .ovc_allocated (ovc_allocated)
);

`default_nettype wire

//--- testbench/allocator_tb.sv
`timescale 1ns/1ps
`default_nettype none

module allocator_tb
    import noc_cfg_pkg::*, alloc_types_pkg::*;
();

    localparam int          CLK_PERIOD     = 100;
    localparam int          RST_CYCLES     = 10;
    localparam int          NUM_ROWS       = 12;
    localparam int          TIMEOUT_CYCLES = RST_CYCLES + NUM_ROWS + 20;
    localparam logic [31:0] SEED           = 32'hfd82d07e;

    logic         clk;
    logic         rst;
    ivc_info_t    ivc_info [NUM_PORTS][NUM_VCS];
    port_mask_t   iport_weight_consumed;
    iport_grant_t iport_grant [NUM_PORTS];
    port_mask_t   any_sw_grant;
    port_mask_t   any_out_grant;
    vc_mask_t     ovc_allocated [NUM_PORTS];
    port_mask_t   single_flit_dst;

    // stimulus and expected results, one row per cycle
    string        row_name  [NUM_ROWS];
    ivc_info_t    row_info  [NUM_ROWS][NUM_PORTS][NUM_VCS];
    port_mask_t   row_wc    [NUM_ROWS];
    iport_grant_t row_grant [NUM_ROWS][NUM_PORTS];
    vc_mask_t     row_ovc   [NUM_ROWS][NUM_PORTS];  // expected ovc_allocated
    port_mask_t   row_out   [NUM_ROWS];
    port_mask_t   row_sf    [NUM_ROWS];

    int n_rows;
    int cur;

    comb_nonspec_allocator comb_nonspec_allocator_inst (
        .clk                   (clk),
        .rst                   (rst),
        .ivc_info              (ivc_info),
        .iport_weight_consumed (iport_weight_consumed),
        .iport_grant           (iport_grant),
        .any_sw_grant          (any_sw_grant),
        .any_out_grant         (any_out_grant),
        .ovc_allocated         (ovc_allocated),
        .single_flit_dst       (single_flit_dst)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // no request at all, remaining fields are noise
    function automatic ivc_info_t idle_vc();
        logic [31:0] rnd;
        ivc_info_t   vc;
        rnd        = $urandom;
        vc         = rnd[$bits(ivc_info_t)-1:0];
        vc.req     = 1'b0;
        vc.ovc_req = '0;
        return vc;
    endfunction

    function automatic ivc_info_t busy_vc(input logic assigned, input logic not_full,
                                          input logic sf, input logic wc,
                                          input dst_mask_t dest, input vc_mask_t ovc_req);
        ivc_info_t vc;
        vc.req             = 1'b1;
        vc.ovc_assigned    = assigned;
        vc.ovc_not_full    = not_full;
        vc.single_flit     = sf;
        vc.weight_consumed = wc;
        vc.dest            = dest;
        vc.ovc_req         = ovc_req;
        return vc;
    endfunction

    task automatic new_row(input string name, input port_mask_t wc);
        cur = n_rows;
        for (int p = 0; p < NUM_PORTS; p++) begin
            for (int v = 0; v < NUM_VCS; v++) begin
                row_info[cur][p][v] = idle_vc();
            end
            row_grant[cur][p] = '0;
            row_ovc[cur][p]   = '0;
        end
        row_name[cur] = name;
        row_wc[cur]   = wc;
        row_out[cur]  = '0;
        row_sf[cur]   = '0;
        n_rows        = n_rows + 1;
    endtask

    task automatic expect_port(input int p, input vc_mask_t sw, input dst_mask_t dst,
                               input vc_mask_t ovc, input vc_mask_t gets);
        row_grant[cur][p].sw_grant     = sw;
        row_grant[cur][p].dst_grant    = dst;
        row_grant[cur][p].ovc_num      = ovc;
        row_grant[cur][p].ivc_gets_ovc = gets;
    endtask

    // inputs 2 and 4 both ask for output 1
    task automatic conflict_row(input string name, input port_mask_t wc, input int winner);
        new_row(name, wc);
        row_info[cur][2][0] = busy_vc(1'b1, 1'b1, 1'b0, 1'b0, 4'b0010, '0);
        row_info[cur][4][0] = busy_vc(1'b1, 1'b1, 1'b0, 1'b0, 4'b0010, '0);
        expect_port(winner, 2'b01, 4'b0010, '0, '0);
        row_out[cur] = 5'b00010;
    endtask

    task automatic build_table();
        new_row("lone_request", 5'b00000);
        row_info[cur][1][0] = busy_vc(1'b1, 1'b1, 1'b0, 1'b0, 4'b0100, '0);
        expect_port(1, 2'b01, 4'b0100, '0, '0);  // relative 2 is output 3
        row_out[cur] = 5'b01000;

        conflict_row("conflict_rr", 5'b10100, 2);
        conflict_row("conflict_rr", 5'b10100, 4);
        conflict_row("conflict_rr", 5'b10100, 2);
        conflict_row("weight_hold", 5'b00000, 4);
        conflict_row("weight_hold", 5'b00000, 4);

        new_row("vc_masking", 5'b00000);
        row_info[cur][3][0] = busy_vc(1'b1, 1'b0, 1'b0, 1'b0, 4'b1000, '0);  // full ovc
        row_info[cur][3][1] = busy_vc(1'b1, 1'b1, 1'b0, 1'b0, 4'b0001, '0);
        expect_port(3, 2'b10, 4'b0001, '0, '0);
        row_out[cur] = 5'b00001;

        for (int r = 0; r < 2; r++) begin
            new_row("ovc_alloc", 5'b00000);
            row_info[cur][0][1] = busy_vc(1'b0, 1'b1, 1'b0, 1'b0, 4'b0010, 2'b11);
            expect_port(0, 2'b10, 4'b0010, (r == 0) ? 2'b01 : 2'b10, 2'b10);
            row_ovc[cur][2] = (r == 0) ? 2'b01 : 2'b10;
            row_out[cur]    = 5'b00100;
        end

        new_row("single_flit", 5'b00000);
        row_info[cur][0][0] = busy_vc(1'b1, 1'b1, 1'b0, 1'b0, 4'b0001, '0);  // to output 1
        row_info[cur][1][1] = busy_vc(1'b1, 1'b1, 1'b1, 1'b1, 4'b1000, '0);  // to output 4
        row_info[cur][4][0] = busy_vc(1'b1, 1'b1, 1'b1, 1'b1, 4'b0100, '0);  // to output 2
        expect_port(0, 2'b01, 4'b0001, '0, '0);
        expect_port(1, 2'b10, 4'b1000, '0, '0);
        expect_port(4, 2'b01, 4'b0100, '0, '0);
        row_out[cur] = 5'b10110;
        row_sf[cur]  = 5'b10100;

        // input 4 pointer moved past vc 0 in the row before
        new_row("input_rr", 5'b00000);
        row_info[cur][4][0] = busy_vc(1'b1, 1'b1, 1'b0, 1'b0, 4'b0100, '0);
        row_info[cur][4][1] = busy_vc(1'b1, 1'b1, 1'b0, 1'b0, 4'b0001, '0);
        expect_port(4, 2'b10, 4'b0001, '0, '0);
        row_out[cur] = 5'b00001;

        new_row("idle", 5'b00000);
    endtask

    task automatic apply_row(input int i);
        for (int p = 0; p < NUM_PORTS; p++) begin
            for (int v = 0; v < NUM_VCS; v++) begin
                ivc_info[p][v] = row_info[i][p][v];
            end
        end
        iport_weight_consumed = row_wc[i];
    endtask

    task automatic check_field(input string name, input string what,
                               input logic [15:0] exp, input logic [15:0] act);
        assert (act === exp) else begin
            $display("[FAIL] %s %s: expected %0h, actual %0h", name, what, exp, act);
            $display("*** TEST FAILED ***");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    task automatic check_row(input int i);
        port_mask_t exp_won;
        string      nm;
        nm = $sformatf("%s (row %0d)", row_name[i], i);
        for (int p = 0; p < NUM_PORTS; p++) begin
            exp_won[p] = |row_grant[i][p].sw_grant;
            check_field(nm, $sformatf("port %0d sw_grant", p),
                        16'(row_grant[i][p].sw_grant), 16'(iport_grant[p].sw_grant));
            check_field(nm, $sformatf("port %0d dst_grant", p),
                        16'(row_grant[i][p].dst_grant), 16'(iport_grant[p].dst_grant));
            check_field(nm, $sformatf("port %0d ovc_num", p),
                        16'(row_grant[i][p].ovc_num), 16'(iport_grant[p].ovc_num));
            check_field(nm, $sformatf("port %0d ivc_gets_ovc", p),
                        16'(row_grant[i][p].ivc_gets_ovc), 16'(iport_grant[p].ivc_gets_ovc));
            check_field(nm, $sformatf("output %0d ovc_allocated", p),
                        16'(row_ovc[i][p]), 16'(ovc_allocated[p]));
        end
        check_field(nm, "any_sw_grant", 16'(exp_won), 16'(any_sw_grant));
        check_field(nm, "any_out_grant", 16'(row_out[i]), 16'(any_out_grant));
        check_field(nm, "single_flit_dst", 16'(row_sf[i]), 16'(single_flit_dst));
    endtask

    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("timeout, the allocator test ran longer than %0d cycles", TIMEOUT_CYCLES);
        $display("*** TEST FAILED ***");
        $fatal(1, "watchdog expired");
    end

    initial begin
        clk                   = 1'b0;
        rst                   = 1'b1;
        iport_weight_consumed = '0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            for (int v = 0; v < NUM_VCS; v++) begin
                ivc_info[p][v] = '0;
            end
        end
        n_rows = 0;
        void'($urandom(SEED));
        build_table();
        assert (n_rows == NUM_ROWS) else begin
            $display("stimulus table holds %0d rows, %0d expected", n_rows, NUM_ROWS);
            $display("*** TEST FAILED ***");
            $fatal(1, "bad stimulus table");
        end

        repeat (RST_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;

        for (int i = 0; i < NUM_ROWS; i++) begin
            @(posedge clk);
            #1;
            apply_row(i);
            #90;  // just before the next edge
            check_row(i);
        end

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire
